// ==== project.f ====
+incdir+design
design/spk_pkg.sv
design/param_bank.sv
design/tick_gen.sv
design/synapse.sv
design/lif_neuron.sv
design/spike_counter.sv
design/spiking_top.sv
sim/tb_spiking_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the spiking channel testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    -f project.f \
    --top-module tb_spiking_top \
    -o tb_spiking_top

# a $fatal in the testbench gives a nonzero exit status
./obj_dir/tb_spiking_top

// ==== sim/tb_spiking_top.sv ====
`timescale 1ns/1ps
`include "spk_params.svh"

module tb_spiking_top;

    //////////////////////////////////////////////////////////////////////
    // stimulus table
    //////////////////////////////////////////////////////////////////////

    localparam logic [1:0] MODE_NONE   = 2'd0;
    localparam logic [1:0] MODE_EVERY  = 2'd1;
    localparam logic [1:0] MODE_RANDOM = 2'd2;
    localparam int         NUM_STIM    = 11;
    localparam int         MARGIN      = 64;

    // one table row
    // spk_min and spk_max bound the o_spike_out pulses seen in the row
    typedef struct packed {
        spk_pkg::trig_t      trig;
        spk_pkg::host_word_t wire_lo;
        spk_pkg::host_word_t wire_hi;
        logic [15:0]         cycles;
        logic [1:0]          mode;
        logic [7:0]          period;
        logic [15:0]         spk_min;
        logic [15:0]         spk_max;
    } stim_t;

    stim_t stim_tbl [NUM_STIM];

    logic                ep50trig = 1'b0;
    logic                reset_global;
    spk_pkg::trig_t      trig;
    spk_pkg::host_word_t wire_lo;
    spk_pkg::host_word_t wire_hi;
    logic                spike_in;
    spk_pkg::current_t   o_current;
    spk_pkg::current_t   o_drive;
    logic                o_spike_out;
    spk_pkg::count_t     o_spike_count;
    logic                o_count_valid;

    // cycle model state
    logic [15:0]                 m_half_cnt;
    int                          m_weight;
    logic [3:0]                  m_decay;
    logic [3:0]                  m_leak;
    shortint                     m_gain;
    int                          m_thr;
    logic [15:0]                 m_cyc;
    logic [`SPK_WINDOW_LOG2-1:0] m_win;
    logic                        m_pending;
    int                          m_current;
    int                          m_drive;
    int                          m_pot;
    logic                        m_spike;
    logic [15:0]                 m_cnt;
    logic [15:0]                 m_count;
    logic                        m_valid;

    int win_spikes   = 0;
    int spike_total  = 0;
    int cycle_count  = 0;
    int cycle_limit  = 0;

    always #50 ep50trig = ~ep50trig;

    spiking_top dut0 (
        .i_ep50trig     (ep50trig),
        .i_reset_global (reset_global),
        .i_trig         (trig),
        .i_wire_lo      (wire_lo),
        .i_wire_hi      (wire_hi),
        .i_spike_in     (spike_in),
        .o_current      (o_current),
        .o_drive        (o_drive),
        .o_spike_out    (o_spike_out),
        .o_spike_count  (o_spike_count),
        .o_count_valid  (o_count_valid)
    );

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("MISMATCH time=%0t signal=%s dut=%0h expected=%0h",
                     $time, name, actual, expected);
            $display("Result: FAILED");
            $fatal(1, "value check failed");
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // cycle model
    //////////////////////////////////////////////////////////////////////

    // one clock edge, all inputs as sampled on that edge
    task automatic advance_model();
        logic        tick;
        logic        win_close;
        logic        seen;
        longint      prod;
        int          drive_n;
        int          pot_sum;
        int          cur_n;
        logic        fire;
        logic [15:0] cnt_n;
        if (reset_global)
        begin
            m_half_cnt = `SPK_DEF_HALF_CNT;
            m_weight   = int'(`SPK_DEF_WEIGHT);
            m_decay    = `SPK_DEF_DECAY_SHIFT;
            m_leak     = `SPK_DEF_LEAK_SHIFT;
            m_gain     = shortint'(`SPK_DEF_GAIN);
            m_thr      = int'(`SPK_DEF_THRESHOLD);
            m_cyc      = '0;
            m_win      = '0;
            m_pending  = 1'b0;
            m_current  = 0;
            m_drive    = 0;
            m_pot      = 0;
            m_spike    = 1'b0;
            m_cnt      = '0;
            m_count    = '0;
            m_valid    = 1'b0;
        end
        else
        begin
            tick      = (m_cyc >= m_half_cnt);
            win_close = tick && (m_win == {`SPK_WINDOW_LOG2{1'b1}});
            // neuron takes the current before this tick's synapse step
            prod    = longint'(m_current) * longint'(m_gain);
            drive_n = int'(prod);
            pot_sum = m_pot - (m_pot >>> m_leak) + drive_n;
            fire    = (pot_sum >= m_thr);
            // spike on the tick cycle itself still counts
            seen  = m_pending | spike_in;
            cur_n = m_current - (m_current >>> m_decay) + (seen ? m_weight : 0);
            // counter sees the spike from the previous tick
            cnt_n = m_cnt;
            if (m_spike && (m_cnt != 16'hffff))
                cnt_n = m_cnt + 16'd1;
            if (win_close)
            begin
                m_count = cnt_n;
                m_cnt   = '0;
            end
            else
                m_cnt = cnt_n;
            m_valid = win_close;
            m_spike = tick & fire;
            if (tick)
            begin
                m_current = cur_n;
                m_drive   = drive_n;
                m_pot     = fire ? 0 : pot_sum;
                m_pending = 1'b0;
                m_win     = m_win + 1'b1;
                m_cyc     = '0;
            end
            else
            begin
                if (spike_in)
                    m_pending = 1'b1;
                m_cyc = m_cyc + 16'd1;
            end
            // config lands after this edge
            if (trig[0])
                m_half_cnt = wire_lo;
            if (trig[1])
                m_weight = int'({16'h0000, wire_lo});
            if (trig[2])
            begin
                m_decay = wire_lo[3:0];
                m_leak  = wire_lo[7:4];
            end
            if (trig[3])
                m_gain = shortint'(wire_lo);
            if (trig[4])
                m_thr = int'({wire_hi, wire_lo});
        end
    endtask

    always @(posedge ep50trig)
    begin
        advance_model();
    end

    // outputs compared mid-cycle where they are stable
    always @(negedge ep50trig)
    begin
        check_value("neuron_tick", dut0.neuron_tick, m_cyc >= m_half_cnt);
        check_value("window_tick", dut0.window_tick,
                    (m_cyc >= m_half_cnt) && (m_win == {`SPK_WINDOW_LOG2{1'b1}}));
        check_value("o_current", o_current, m_current);
        check_value("o_drive", o_drive, m_drive);
        check_value("o_spike_out", o_spike_out, m_spike);
        check_value("o_count_valid", o_count_valid, m_valid);
        check_value("o_spike_count", o_spike_count, m_count);
        // window total against pulses actually seen
        if (o_count_valid)
        begin
            check_value("spikes per window", o_spike_count, win_spikes);
            win_spikes = 0;
        end
        if (o_spike_out)
        begin
            win_spikes  = win_spikes + 1;
            spike_total = spike_total + 1;
        end
    end

    // hang guard
    always @(posedge ep50trig)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit)
        begin
            $display("timeout: run exceeded %0d clock cycles", cycle_limit);
            $display("Result: FAILED");
            $fatal(1, "simulation did not finish in time");
        end
    end

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        stim_t entry;
        int    e;
        int    c;
        int    start_spikes;
        int    got;
        void'($urandom(32'ha77006a0));
        // trig, wire_lo, wire_hi, cycles, mode, period, spike min, spike max
        stim_tbl[0] = '{16'h0000, 16'd0, 16'd0, 16'd140, MODE_NONE, 8'd1, 16'd0, 16'd0};
        // upper trigger bit and hi word play no part in this load
        stim_tbl[1] = '{16'h8001, 16'd5, 16'h00c3, 16'd100, MODE_NONE, 8'd1, 16'd0, 16'd0};
        stim_tbl[2] = '{16'h0002, 16'd1000, 16'd0, 16'd120, MODE_EVERY, 8'd40,
                        16'd0, 16'hffff};
        // single spike, decay 1 and leak 3
        stim_tbl[3] = '{16'h0004, 16'h0031, 16'd0, 16'd120, MODE_EVERY, 8'd200,
                        16'd0, 16'hffff};
        stim_tbl[4] = '{16'h0008, 16'd3, 16'd0, 16'd10, MODE_NONE, 8'd1, 16'd0, 16'hffff};
        stim_tbl[5] = '{16'h0010, 16'd1500, 16'd0, 16'd200, MODE_EVERY, 8'd30,
                        16'd1, 16'hffff};
        // negative gain of -2 drives the membrane down
        stim_tbl[6] = '{16'h0008, 16'hfffe, 16'd0, 16'd150, MODE_EVERY, 8'd25,
                        16'd0, 16'd2};
        stim_tbl[7] = '{16'h0008, 16'd4, 16'd0, 16'd20, MODE_NONE, 8'd1, 16'd0, 16'hffff};
        stim_tbl[8] = '{16'h0001, 16'd2, 16'd0, 16'd400, MODE_RANDOM, 8'd4,
                        16'd1, 16'hffff};
        // weight and shifts from one word in one cycle
        stim_tbl[9] = '{16'h0006, 16'h0024, 16'h0a0a, 16'd300, MODE_RANDOM, 8'd3,
                        16'd0, 16'hffff};
        // threshold of 65536 sits wholly in the hi word
        stim_tbl[10] = '{16'h0010, 16'h0000, 16'h0001, 16'd200, MODE_RANDOM, 8'd3,
                         16'd0, 16'd2};
        cycle_limit = 3 + MARGIN;
        for (e = 0; e < NUM_STIM; e++)
            cycle_limit = cycle_limit + int'(stim_tbl[e].cycles);

        reset_global = 1'b1;
        trig         = '0;
        wire_lo      = '0;
        wire_hi      = '0;
        spike_in     = 1'b0;
        repeat (3) @(posedge ep50trig);
        reset_global <= 1'b0;

        for (e = 0; e < NUM_STIM; e++)
        begin
            entry        = stim_tbl[e];
            start_spikes = spike_total;
            for (c = 0; c < int'(entry.cycles); c++)
            begin
                @(posedge ep50trig);
                // load strobe only on the first cycle of a row
                trig    <= (c == 0) ? entry.trig : '0;
                wire_lo <= entry.wire_lo;
                wire_hi <= entry.wire_hi;
                case (entry.mode)
                    MODE_EVERY:  spike_in <= ((c % int'(entry.period)) == 0);
                    MODE_RANDOM: spike_in <= (($urandom % entry.period) == 0);
                    default:     spike_in <= 1'b0;
                endcase
            end
            got = spike_total - start_spikes;
            check_value("spike pulses in range",
                        (got >= int'(entry.spk_min)) && (got <= int'(entry.spk_max)), 1'b1);
        end

        @(posedge ep50trig);
        trig     <= '0;
        spike_in <= 1'b0;
        repeat (4) @(posedge ep50trig);
        $display("Result: PASSED");
        $finish;
    end

endmodule

// ==== design/spiking_top.sv ====
`timescale 1ns/1ps

module spiking_top
(
    input  logic                i_ep50trig,
    input  logic                i_reset_global,
    input  spk_pkg::trig_t      i_trig,
    input  spk_pkg::host_word_t i_wire_lo,
    input  spk_pkg::host_word_t i_wire_hi,
    input  logic                i_spike_in,
    output spk_pkg::current_t   o_current,
    output spk_pkg::current_t   o_drive,
    output logic                o_spike_out,
    output spk_pkg::count_t     o_spike_count,
    output logic                o_count_valid
);

    spk_pkg::spk_cfg_t cfg;
    logic              neuron_tick;
    logic              window_tick;

    //////////////////////////////////////////////////////////////////////
    // configuration and timing
    //////////////////////////////////////////////////////////////////////

    param_bank param_bank0 (
        .i_ep50trig     (i_ep50trig),
        .i_reset_global (i_reset_global),
        .i_trig         (i_trig),
        .i_wire_lo      (i_wire_lo),
        .i_wire_hi      (i_wire_hi),
        .o_cfg          (cfg)
    );

    tick_gen tick_gen0 (
        .i_ep50trig     (i_ep50trig),
        .i_reset_global (i_reset_global),
        .i_half_cnt     (cfg.half_cnt),
        .o_neuron_tick  (neuron_tick),
        .o_window_tick  (window_tick)
    );

    //////////////////////////////////////////////////////////////////////
    // spiking channel
    //////////////////////////////////////////////////////////////////////

    // synapse fed by the cross-board spike
    synapse synapse0 (
        .i_ep50trig     (i_ep50trig),
        .i_reset_global (i_reset_global),
        .i_tick         (neuron_tick),
        .i_spike_in     (i_spike_in),
        .i_weight       (cfg.weight),
        .i_decay_shift  (cfg.decay_shift),
        .o_current      (o_current)
    );

    // neuron sees pre-update current on the shared tick
    lif_neuron lif_neuron0 (
        .i_ep50trig     (i_ep50trig),
        .i_reset_global (i_reset_global),
        .i_tick         (neuron_tick),
        .i_current      (o_current),
        .i_gain         (cfg.gain),
        .i_leak_shift   (cfg.leak_shift),
        .i_threshold    (cfg.threshold),
        .o_drive        (o_drive),
        .o_spike        (o_spike_out)
    );

    spike_counter spike_counter0 (
        .i_ep50trig     (i_ep50trig),
        .i_reset_global (i_reset_global),
        .i_spike        (o_spike_out),
        .i_window_tick  (window_tick),
        .o_count        (o_spike_count),
        .o_count_valid  (o_count_valid)
    );

endmodule

// ==== design/spike_counter.sv ====
`timescale 1ns/1ps

module spike_counter
(
    input  logic            i_ep50trig,
    input  logic            i_reset_global,
    input  logic            i_spike,
    input  logic            i_window_tick,
    output spk_pkg::count_t o_count,
    output logic            o_count_valid
);

    spk_pkg::count_t cnt_q;
    spk_pkg::count_t cnt_next;
    spk_pkg::count_t count_q;
    logic            valid_q;

    // saturating increment
    // holds at all ones
    always_comb
    begin
        cnt_next = cnt_q;
        if (i_spike && (cnt_q != '1))
            cnt_next = cnt_q + 1'b1;
    end

    always_ff @(posedge i_ep50trig)
    begin
        if (i_reset_global)
        begin
            cnt_q   <= '0;
            count_q <= '0;
            valid_q <= 1'b0;
        end
        else if (i_window_tick)
        begin
            // publish incl. spike on the closing cycle
            count_q <= cnt_next;
            cnt_q   <= '0;
            valid_q <= 1'b1;
        end
        else
        begin
            cnt_q   <= cnt_next;
            valid_q <= 1'b0;
        end
    end

    // count held between windows
    assign o_count       = count_q;
    assign o_count_valid = valid_q;

endmodule

// ==== design/lif_neuron.sv ====
`timescale 1ns/1ps

module lif_neuron
(
    input  logic                i_ep50trig,
    input  logic                i_reset_global,
    input  logic                i_tick,
    input  spk_pkg::current_t   i_current,
    input  spk_pkg::gain_t      i_gain,
    input  spk_pkg::shift_t     i_leak_shift,
    input  spk_pkg::potential_t i_threshold,
    output spk_pkg::current_t   o_drive,
    output logic                o_spike
);

    // full product width before truncation
    localparam int PROD_W = $bits(spk_pkg::current_t) + $bits(spk_pkg::gain_t);

    logic signed [PROD_W-1:0] product;
    spk_pkg::current_t        drive_next;
    spk_pkg::current_t        drive_q;
    spk_pkg::potential_t      leak_step;
    spk_pkg::potential_t      pot_sum;
    spk_pkg::potential_t      pot_q;
    logic                     fire;
    logic                     spike_q;

    //////////////////////////////////////////////////////////////////////
    // gain stage
    //////////////////////////////////////////////////////////////////////

    // signed multiply, low word kept
    // wraps on overflow
    assign product    = i_current * i_gain;
    assign drive_next = spk_pkg::current_t'(product[$bits(spk_pkg::current_t)-1:0]);

    //////////////////////////////////////////////////////////////////////
    // membrane
    //////////////////////////////////////////////////////////////////////

    // leak by shift, then integrate the new drive
    always_comb
    begin
        leak_step = pot_q >>> i_leak_shift;
        pot_sum   = pot_q - leak_step + drive_next;
        fire      = (pot_sum >= i_threshold);
    end

    always_ff @(posedge i_ep50trig)
    begin
        if (i_reset_global)
        begin
            drive_q <= '0;
            pot_q   <= '0;
            spike_q <= 1'b0;
        end
        else
        begin
            // spike is one cycle wide
            spike_q <= i_tick & fire;
            if (i_tick)
            begin
                drive_q <= drive_next;
                // restart from rest on a crossing
                if (fire)
                    pot_q <= '0;
                else
                    pot_q <= pot_sum;
            end
        end
    end

    assign o_drive = drive_q;
    assign o_spike = spike_q;

endmodule

// ==== design/synapse.sv ====
`timescale 1ns/1ps

module synapse
(
    input  logic              i_ep50trig,
    input  logic              i_reset_global,
    input  logic              i_tick,
    input  logic              i_spike_in,
    input  spk_pkg::weight_t  i_weight,
    input  spk_pkg::shift_t   i_decay_shift,
    output spk_pkg::current_t o_current
);

    logic              pending_q;
    logic              spike_seen;
    spk_pkg::current_t current_q;
    spk_pkg::current_t weight_ext;
    spk_pkg::current_t decay_step;
    spk_pkg::current_t current_next;

    // spike held until the next tick
    // a spike on the tick itself still counts
    assign spike_seen = pending_q | i_spike_in;

    always_ff @(posedge i_ep50trig)
    begin
        if (i_reset_global)
            pending_q <= 1'b0;
        else if (i_tick)
            pending_q <= 1'b0;
        else if (i_spike_in)
            pending_q <= 1'b1;
    end

    // weight is unsigned, zero extend
    assign weight_ext = spk_pkg::current_t'({{($bits(spk_pkg::current_t)
                        - $bits(spk_pkg::weight_t)){1'b0}}, i_weight});

    // exponential decay by arithmetic shift
    always_comb
    begin
        decay_step   = current_q >>> i_decay_shift;
        current_next = current_q - decay_step;
        if (spike_seen)
            current_next = current_next + weight_ext;
    end

    // current only moves on tick cycles
    always_ff @(posedge i_ep50trig)
    begin
        if (i_reset_global)
            current_q <= '0;
        else if (i_tick)
            current_q <= current_next;
    end

    assign o_current = current_q;

endmodule

// ==== design/tick_gen.sv ====
`timescale 1ns/1ps
`include "spk_params.svh"

module tick_gen
(
    input  logic               i_ep50trig,
    input  logic               i_reset_global,
    input  spk_pkg::half_cnt_t i_half_cnt,
    output logic               o_neuron_tick,
    output logic               o_window_tick
);

    //////////////////////////////////////////////////////////////////////
    // neuron rate divider
    //////////////////////////////////////////////////////////////////////

    spk_pkg::half_cnt_t cyc_cnt_q;
    logic [`SPK_WINDOW_LOG2-1:0] win_cnt_q;

    // tick once counter reaches period minus one
    // >= also catches a period shortened mid-count
    assign o_neuron_tick = (cyc_cnt_q >= i_half_cnt);

    always_ff @(posedge i_ep50trig)
    begin
        if (i_reset_global)
            cyc_cnt_q <= '0;
        else if (o_neuron_tick)
            cyc_cnt_q <= '0;
        else
            cyc_cnt_q <= cyc_cnt_q + 1'b1;
    end

    //////////////////////////////////////////////////////////////////////
    // counting window
    //////////////////////////////////////////////////////////////////////

    // neuron ticks seen in current window, wraps
    always_ff @(posedge i_ep50trig)
    begin
        if (i_reset_global)
            win_cnt_q <= '0;
        else if (o_neuron_tick)
            win_cnt_q <= win_cnt_q + 1'b1;
    end

    // last tick of the group closes the window
    assign o_window_tick = o_neuron_tick && (&win_cnt_q);

endmodule

// ==== design/param_bank.sv ====
`timescale 1ns/1ps
`include "spk_params.svh"

module param_bank
(
    input  logic                i_ep50trig,
    input  logic                i_reset_global,
    input  spk_pkg::trig_t      i_trig,
    input  spk_pkg::host_word_t i_wire_lo,
    input  spk_pkg::host_word_t i_wire_hi,
    output spk_pkg::spk_cfg_t   o_cfg
);

    // trigger bit per register
    localparam int TRIG_HALF_CNT  = 0;
    localparam int TRIG_WEIGHT    = 1;
    localparam int TRIG_SHIFTS    = 2;
    localparam int TRIG_GAIN      = 3;
    localparam int TRIG_THRESHOLD = 4;

    spk_pkg::spk_cfg_t cfg_q;

    // tick period
    always_ff @(posedge i_ep50trig)
    begin
        if (i_reset_global)
            cfg_q.half_cnt <= `SPK_DEF_HALF_CNT;
        else if (i_trig[TRIG_HALF_CNT])
            cfg_q.half_cnt <= i_wire_lo;
    end

    // synaptic weight
    always_ff @(posedge i_ep50trig)
    begin
        if (i_reset_global)
            cfg_q.weight <= `SPK_DEF_WEIGHT;
        else if (i_trig[TRIG_WEIGHT])
            cfg_q.weight <= i_wire_lo;
    end

    // decay in low nibble, leak in next nibble
    always_ff @(posedge i_ep50trig)
    begin
        if (i_reset_global)
        begin
            cfg_q.decay_shift <= `SPK_DEF_DECAY_SHIFT;
            cfg_q.leak_shift  <= `SPK_DEF_LEAK_SHIFT;
        end
        else if (i_trig[TRIG_SHIFTS])
        begin
            cfg_q.decay_shift <= i_wire_lo[3:0];
            cfg_q.leak_shift  <= i_wire_lo[7:4];
        end
    end

    // signed synapse gain
    always_ff @(posedge i_ep50trig)
    begin
        if (i_reset_global)
            cfg_q.gain <= `SPK_DEF_GAIN;
        else if (i_trig[TRIG_GAIN])
            cfg_q.gain <= spk_pkg::gain_t'(i_wire_lo);
    end

    // threshold spans both wires, hi word on top
    always_ff @(posedge i_ep50trig)
    begin
        if (i_reset_global)
            cfg_q.threshold <= `SPK_DEF_THRESHOLD;
        else if (i_trig[TRIG_THRESHOLD])
            cfg_q.threshold <= spk_pkg::potential_t'({i_wire_hi, i_wire_lo});
    end

    assign o_cfg = cfg_q;

endmodule

// ==== design/spk_pkg.sv ====
`include "spk_params.svh"

package spk_pkg;

    // one host wire value
    typedef logic [`SPK_HOST_W-1:0] host_word_t;
    // load strobes, one bit per register
    typedef logic [`SPK_HOST_W-1:0] trig_t;

    // tick period minus one
    typedef logic [`SPK_HOST_W-1:0] half_cnt_t;
    // unsigned current step per input spike
    typedef logic [`SPK_HOST_W-1:0] weight_t;
    typedef logic [`SPK_SHIFT_W-1:0] shift_t;
    // signed multiplier ahead of the neuron
    typedef logic signed [`SPK_HOST_W-1:0] gain_t;

    // synapse current and gain-adjusted drive
    typedef logic signed [`SPK_DATA_W-1:0] current_t;
    typedef logic signed [`SPK_DATA_W-1:0] potential_t;

    typedef logic [`SPK_COUNT_W-1:0] count_t;

    // full host-set configuration
    typedef struct packed {
        half_cnt_t  half_cnt;
        weight_t    weight;
        shift_t     decay_shift;
        shift_t     leak_shift;
        gain_t      gain;
        potential_t threshold;
    } spk_cfg_t;

endpackage

// ==== design/spk_params.svh ====
`ifndef SPK_PARAMS_SVH
`define SPK_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// datapath widths
//////////////////////////////////////////////////////////////////////

// host wire and trigger endpoint width
`define SPK_HOST_W          16
// current, drive and membrane potential width
`define SPK_DATA_W          32
// right-shift amount for decay and leak
`define SPK_SHIFT_W         4
// per-window spike count width
`define SPK_COUNT_W         16

// log2 of neuron ticks per counting window
`define SPK_WINDOW_LOG2     4

//////////////////////////////////////////////////////////////////////
// configuration reset defaults
//////////////////////////////////////////////////////////////////////

// tick period minus one
`define SPK_DEF_HALF_CNT    16'd3
`define SPK_DEF_WEIGHT      16'd512
`define SPK_DEF_DECAY_SHIFT 4'd3
`define SPK_DEF_LEAK_SHIFT  4'd2
// unity gain
`define SPK_DEF_GAIN        16'h0001
`define SPK_DEF_THRESHOLD   32'd2048

`endif
